// File: sources.f
gomoku_pkg.sv
five_check.sv
threat_scan.sv
move_fifo.sv
kill_node.sv
gomoku_kill_top.sv
tb_gomoku_kill.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_gomoku_kill
FILELIST = sources.f
OBJDIR   = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: tb_gomoku_kill.sv
// testbench for the gomoku kill search, checks each search result against a reference search
`timescale 1ns/1ps

module tb_gomoku_kill
    import gomoku_pkg::*;
();

    localparam int N_TESTS      = 24;
    localparam int DONE_TIMEOUT = 70000;

    logic         i_clk = 1'b0;
    logic         i_rst_n;
    logic         i_start;
    board_t       i_board;
    cell_t        i_attacker;
    logic         o_done;
    kill_result_t o_result;

    // expected results, in the order the searches were started
    kill_result_t exp_q [$];
    string        name_q [$];
    int           tests_started = 0;
    int           checks_done = 0;
    int           pass_count = 0;
    int           fail_count = 0;
    logic         aborted = 1'b0;
    logic [31:0]  rng = 32'h7c130c35;

    gomoku_kill_top u_gomoku_kill_top (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_board    (i_board),
        .i_attacker (i_attacker),
        .o_done     (o_done),
        .o_result   (o_result)
    );

    always #5 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic move_t cell_move(input int i);
        move_t m;
        m.idx = 8'(i);
        m.row = 4'(i / BOARD_N);
        m.col = 4'(i % BOARD_N);
        return m;
    endfunction

    function automatic board_t place(input board_t b, input int r, input int c, input cell_t s);
        board_t n;
        n = b;
        n[r * BOARD_N + c] = s;
        return n;
    endfunction

    // true when a stone of col on cell i completes some window of five on a line
    function automatic logic makes_five(input board_t b, input int i, input cell_t col);
        int   dr [4] = '{0, 1, 1, 1};
        int   dc [4] = '{1, 0, 1, -1};
        int   r0;
        int   c0;
        int   r;
        int   c;
        logic full;
        logic found;
        r0 = i / BOARD_N;
        c0 = i % BOARD_N;
        found = 1'b0;
        for (int d = 0; d < 4; d++) begin
            for (int from = -4; from <= 0; from++) begin
                full = 1'b1;
                for (int k = 0; k < 5; k++) begin
                    r = r0 + (from + k) * dr[d];
                    c = c0 + (from + k) * dc[d];
                    if (r < 0 || r >= BOARD_N || c < 0 || c >= BOARD_N) begin
                        full = 1'b0;
                    end else if (r * BOARD_N + c != i && b[r * BOARD_N + c] != col) begin
                        full = 1'b0;
                    end
                end
                if (full) begin
                    found = 1'b1;
                end
            end
        end
        return found;
    endfunction

    function automatic int count_wins(input board_t b, input cell_t col);
        int n;
        n = 0;
        for (int i = 0; i < CELLS; i++) begin
            if (b[i] == CELL_EMPTY && makes_five(b, i, col)) begin
                n++;
            end
        end
        return n;
    endfunction

    // first win in one, else first cell leaving two wins, else nothing
    function automatic kill_result_t ref_kill(input board_t b, input cell_t col);
        kill_result_t res;
        board_t       trial;
        res.kind = KILL_NONE;
        res.move = '0;
        for (int i = 0; i < CELLS && res.kind == KILL_NONE; i++) begin
            if (b[i] == CELL_EMPTY && makes_five(b, i, col)) begin
                res.kind = KILL_WIN1;
                res.move = cell_move(i);
            end
        end
        for (int i = 0; i < CELLS && res.kind == KILL_NONE; i++) begin
            if (b[i] == CELL_EMPTY) begin
                trial = place(b, i / BOARD_N, i % BOARD_N, col);
                if (count_wins(trial, col) >= 2) begin
                    res.kind = KILL_DOUBLE;
                    res.move = cell_move(i);
                end
            end
        end
        return res;
    endfunction

    // random colors on about 12 percent of cells and a random attacker
    task automatic random_board(output board_t b, output cell_t a);
        b = '0;
        for (int i = 0; i < CELLS; i++) begin
            rng = lcg_step(rng);
            if (rng[31:24] < 8'd31) begin
                b[i] = rng[16] ? CELL_WHITE : CELL_BLACK;
            end
        end
        rng = lcg_step(rng);
        a = rng[28] ? CELL_WHITE : CELL_BLACK;
    endtask

    task automatic run_search(input string name, input board_t b, input cell_t a,
                              input kill_result_t exp, input int repulse_at);
        int     cycles;
        board_t other_b;
        cell_t  other_a;
        if (!aborted) begin
            exp_q.push_back(exp);
            name_q.push_back(name);
            tests_started++;
            @(posedge i_clk);
            i_board    <= b;
            i_attacker <= a;
            i_start    <= 1'b1;
            @(posedge i_clk);
            i_start <= 1'b0;
            cycles = 0;
            while (checks_done < tests_started && !aborted && cycles < DONE_TIMEOUT + 1000) begin
                @(posedge i_clk);
                cycles++;
                if (cycles == repulse_at) begin
                    // a second request while busy is ignored
                    random_board(other_b, other_a);
                    i_board    <= other_b;
                    i_attacker <= other_a;
                    i_start    <= 1'b1;
                end else begin
                    i_start <= 1'b0;
                end
            end
            i_start <= 1'b0;
            if (checks_done < tests_started && !aborted) begin
                $display("no result was checked for %s in time", name);
                fail_count++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic finish_run();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && checks_done == N_TESTS) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin : drive_proc
        board_t       b;
        cell_t        a;
        kill_result_t exp;
        i_rst_n    = 1'b0;
        i_start    = 1'b0;
        i_board    = '0;
        i_attacker = CELL_BLACK;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        b = '0;
        exp.kind = KILL_NONE;
        exp.move = '0;
        run_search("empty board", b, CELL_BLACK, exp, 0);

        // open four on row 7, columns 5 to 8
        for (int c = 5; c <= 8; c++) begin
            b = place(b, 7, c, CELL_BLACK);
        end
        exp.kind = KILL_WIN1;
        exp.move = cell_move(7 * BOARD_N + 4);
        run_search("open four, black attacks", b, CELL_BLACK, exp, 0);
        run_search("open four, white attacks", b, CELL_WHITE, ref_kill(b, CELL_WHITE), 0);

        // one broken three across row 3, one down column 10
        b = '0;
        b = place(b, 3, 2, CELL_BLACK);
        b = place(b, 3, 3, CELL_BLACK);
        b = place(b, 3, 5, CELL_BLACK);
        b = place(b, 6, 10, CELL_BLACK);
        b = place(b, 7, 10, CELL_BLACK);
        b = place(b, 9, 10, CELL_BLACK);
        exp = ref_kill(b, CELL_BLACK);
        if (exp.kind != KILL_DOUBLE) begin
            $display("reference search found no double threat for the broken threes");
            fail_count++;
        end
        run_search("two broken threes", b, CELL_BLACK, exp, 0);

        for (int n = 0; n < 20; n++) begin
            random_board(b, a);
            run_search($sformatf("random board %0d", n), b, a, ref_kill(b, a),
                       (n == 3) ? 40 : 0);
        end
    end

    initial begin : compare_proc
        kill_result_t exp;
        string        name;
        int           cycles;
        logic         bad;
        while (!aborted && checks_done < N_TESTS) begin
            cycles = 0;
            @(negedge i_clk);
            while (!o_done && !aborted && cycles < DONE_TIMEOUT) begin
                @(negedge i_clk);
                cycles++;
            end
            if (!o_done) begin
                if (!aborted) begin
                    $display("o_done never arrived within %0d cycles", DONE_TIMEOUT);
                    fail_count++;
                    aborted = 1'b1;
                end
            end else if (exp_q.size() == 0) begin
                $display("o_done pulsed with no search pending");
                fail_count++;
                aborted = 1'b1;
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                bad  = 1'b0;
                if (o_result.kind != exp.kind) begin
                    $display("Mismatch in %s: o_result.kind got 0x%h expected 0x%h",
                             name, o_result.kind, exp.kind);
                    bad = 1'b1;
                end
                if (o_result.move != exp.move) begin
                    $display("Mismatch in %s: o_result.move got 0x%h expected 0x%h",
                             name, o_result.move, exp.move);
                    bad = 1'b1;
                end
                if (bad) begin
                    fail_count++;
                    $display("%s: failed", name);
                end else begin
                    pass_count++;
                    $display("%s: passed, kind 0x%h move 0x%h", name, exp.kind, exp.move);
                end
                checks_done++;
            end
        end
        finish_run();
    end

endmodule

// File: gomoku_kill_top.sv
// top level of the kill search, joining the kill node, the threat scanner and the move FIFO
`timescale 1ns/1ps

module gomoku_kill_top
    import gomoku_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_start,
    input  board_t       i_board,
    input  cell_t        i_attacker,
    output logic         o_done,
    output kill_result_t o_result
);

    // scan request
    logic   w_scan_start;
    board_t w_scan_board;
    cell_t  w_scan_color;
    logic   w_scan_done;

    // candidate buffer
    logic   w_push;
    move_t  w_push_move;
    logic   w_full;
    logic   w_pop;
    move_t  w_pop_move;
    logic   w_empty;
    logic   w_clear;

    kill_node u_kill_node (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_board      (i_board),
        .i_attacker   (i_attacker),
        .o_scan_start (w_scan_start),
        .o_scan_board (w_scan_board),
        .o_scan_color (w_scan_color),
        .i_scan_done  (w_scan_done),
        .o_pop        (w_pop),
        .i_pop_move   (w_pop_move),
        .i_empty      (w_empty),
        .o_clear      (w_clear),
        .o_done       (o_done),
        .o_result     (o_result)
    );

    threat_scan u_threat_scan (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (w_scan_start),
        .i_board (w_scan_board),
        .i_color (w_scan_color),
        .i_full  (w_full),
        .o_push  (w_push),
        .o_move  (w_push_move),
        .o_done  (w_scan_done)
    );

    move_fifo u_move_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (w_clear),
        .i_push  (w_push),
        .i_move  (w_push_move),
        .i_pop   (w_pop),
        .o_move  (w_pop_move),
        .o_full  (w_full),
        .o_empty (w_empty)
    );

endmodule

// File: kill_node.sv
// kill search FSM that runs the root scan and the trial scans and forms the result
`timescale 1ns/1ps

module kill_node
    import gomoku_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_start,
    input  board_t       i_board,
    input  cell_t        i_attacker,
    output logic         o_scan_start,
    output board_t       o_scan_board,
    output cell_t        o_scan_color,
    input  logic         i_scan_done,
    output logic         o_pop,
    input  move_t        i_pop_move,
    input  logic         i_empty,
    output logic         o_clear,
    output logic         o_done,
    output kill_result_t o_result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ROOT,
        S_TSEL,
        S_TRIAL,
        S_FINISH
    } node_state_t;

    node_state_t  state_r;
    logic         scan_start_r;
    logic         done_r;
    logic         root_hit_r;
    logic [1:0]   hits_r;
    move_t        trial_r;
    kill_kind_t   found_kind_r;
    move_t        found_move_r;
    kill_result_t result_r;

    // search position, captured on start
    board_t       board_r;
    cell_t        attacker_r;

    logic         trial_last;
    logic [1:0]   hits_next;

    // drain the buffer every cycle a scan is running
    assign o_pop = !i_empty && (state_r == S_ROOT || state_r == S_TRIAL);
    // empty the buffer before each trial and after the last scan
    assign o_clear = (state_r == S_TSEL) || (state_r == S_FINISH);

    assign o_scan_start = scan_start_r;
    assign o_scan_color = attacker_r;
    assign o_done       = done_r;
    assign o_result     = result_r;

    assign trial_last = (trial_r.idx == 8'(CELLS - 1));
    // two wins are enough, so saturate there
    assign hits_next  = (hits_r == 2'd2) ? hits_r : hits_r + {1'b0, o_pop};

    // working copy with the trial stone placed
    always_comb begin
        o_scan_board = board_r;
        if (state_r == S_TRIAL) begin
            o_scan_board[trial_r.idx] = attacker_r;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && i_start) begin
            board_r    <= i_board;
            attacker_r <= i_attacker;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r      <= S_IDLE;
            scan_start_r <= 1'b0;
            done_r       <= 1'b0;
            root_hit_r   <= 1'b0;
            hits_r       <= 2'd0;
            trial_r      <= '0;
            found_kind_r <= KILL_NONE;
            found_move_r <= '0;
            result_r     <= '{kind: KILL_NONE, move: '0};
        end else begin
            scan_start_r <= 1'b0;
            done_r       <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        root_hit_r   <= 1'b0;
                        scan_start_r <= 1'b1;
                        state_r      <= S_ROOT;
                    end
                end
                S_ROOT: begin
                    // ascending scan order makes the first pop the lowest win
                    if (o_pop && !root_hit_r) begin
                        root_hit_r   <= 1'b1;
                        found_move_r <= i_pop_move;
                    end
                    if (i_scan_done) begin
                        if (root_hit_r || o_pop) begin
                            found_kind_r <= KILL_WIN1;
                            state_r      <= S_FINISH;
                        end else begin
                            trial_r <= '0;
                            state_r <= S_TSEL;
                        end
                    end
                end
                S_TSEL: begin
                    if (board_r[trial_r.idx] == CELL_EMPTY) begin
                        hits_r       <= 2'd0;
                        scan_start_r <= 1'b1;
                        state_r      <= S_TRIAL;
                    end else if (trial_last) begin
                        found_kind_r <= KILL_NONE;
                        found_move_r <= '0;
                        state_r      <= S_FINISH;
                    end else begin
                        trial_r <= next_cell(trial_r);
                    end
                end
                S_TRIAL: begin
                    hits_r <= hits_next;
                    if (i_scan_done) begin
                        if (hits_next == 2'd2) begin
                            found_kind_r <= KILL_DOUBLE;
                            found_move_r <= trial_r;
                            state_r      <= S_FINISH;
                        end else if (trial_last) begin
                            found_kind_r <= KILL_NONE;
                            found_move_r <= '0;
                            state_r      <= S_FINISH;
                        end else begin
                            trial_r <= next_cell(trial_r);
                            state_r <= S_TSEL;
                        end
                    end
                end
                S_FINISH: begin
                    result_r <= '{kind: found_kind_r, move: found_move_r};
                    done_r   <= 1'b1;
                    state_r  <= S_IDLE;
                end
                default: begin
                    state_r <= S_IDLE;
                end
            endcase
        end
    end

    a_done_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_done
    );

    // the node keeps pace with the scanner and leaves no move behind
    a_drained_after_scan: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_scan_done |=> i_empty
    );

endmodule

// File: move_fifo.sv
// first-word-fall-through buffer of candidate moves between the scanner and the kill node
`timescale 1ns/1ps

module move_fifo
    import gomoku_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_clear,
    input  logic  i_push,
    input  move_t i_move,
    input  logic  i_pop,
    output move_t o_move,
    output logic  o_full,
    output logic  o_empty
);

    move_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_r;
    logic [FIFO_AW-1:0] rd_ptr_r;
    logic [FIFO_AW:0]   count_r;

    logic do_push;
    logic do_pop;

    assign o_full  = (count_r == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign o_empty = (count_r == '0);
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    // head of queue is always on the output
    assign o_move = mem[rd_ptr_r];

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr_r] <= i_move;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else if (i_clear) begin
            // drop anything left from the previous scan
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        count_r <= (FIFO_AW + 1)'(FIFO_DEPTH)
    );

endmodule

// File: threat_scan.sv
// producer that walks every cell of a board and pushes each empty cell that completes five
`timescale 1ns/1ps

module threat_scan
    import gomoku_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    input  board_t i_board,
    input  cell_t  i_color,
    input  logic   i_full,
    output logic   o_push,
    output move_t  o_move,
    output logic   o_done
);

    logic  busy_r;
    logic  done_r;
    move_t cur_r;

    logic  five;
    logic  hit;
    logic  stall;
    logic  last;

    five_check u_five_check (
        .i_board (i_board),
        .i_cell  (cur_r),
        .i_color (i_color),
        .o_five  (five)
    );

    // winning cell must still be empty on the board being scanned
    assign hit   = busy_r && (i_board[cur_r.idx] == CELL_EMPTY) && five;
    // hold the cell and retry while the buffer is full
    assign stall = hit && i_full;
    assign last  = (cur_r.idx == 8'(CELLS - 1));

    assign o_push = hit && !i_full;
    assign o_move = cur_r;
    assign o_done = done_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            done_r <= 1'b0;
            cur_r  <= '0;
        end else begin
            done_r <= 1'b0;
            if (!busy_r) begin
                if (i_start) begin
                    busy_r <= 1'b1;
                    cur_r  <= '0;
                end
            end else if (!stall) begin
                if (last) begin
                    // done follows one cycle after the last cell
                    busy_r <= 1'b0;
                    done_r <= 1'b1;
                end else begin
                    cur_r <= next_cell(cur_r);
                end
            end
        end
    end

    // board and color must hold still until the scan is over
    a_input_stable_while_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        busy_r |-> ($stable(i_board) && $stable(i_color))
    );

endmodule

// File: five_check.sv
// combinational five-in-a-row test for one stone on one cell, used by the threat scanner
`timescale 1ns/1ps

module five_check
    import gomoku_pkg::*;
(
    input  board_t i_board,
    input  move_t  i_cell,
    input  cell_t  i_color,
    output logic   o_five
);

    // one flag per direction
    logic [3:0] dir_five;

    always_comb begin
        int   r;
        int   c;
        int   step;
        int   len;
        logic run_on;

        dir_five = 4'b0;
        for (int d = 0; d < 4; d++) begin
            // the cell under test counts as one stone
            len = 1;
            for (int s = 0; s < 2; s++) begin
                run_on = 1'b1;
                for (int k = 1; k <= RUN_MAX; k++) begin
                    step = (s == 0) ? k : -k;
                    r = int'(i_cell.row) + step * DIR_DR[d];
                    c = int'(i_cell.col) + step * DIR_DC[d];
                    // run stops at the edge or at the first foreign cell
                    if (r < 0 || r >= BOARD_N || c < 0 || c >= BOARD_N) begin
                        run_on = 1'b0;
                    end else if (i_board[r * BOARD_N + c] != i_color) begin
                        run_on = 1'b0;
                    end
                    if (run_on) begin
                        len = len + 1;
                    end
                end
            end
            // overlines count as a win too
            dir_five[d] = (len >= WIN_LEN);
        end
    end

    assign o_five = |dir_five;

endmodule

// File: gomoku_pkg.sv
// shared board, move and result types for the gomoku kill search, imported by every module
package gomoku_pkg;

    // board geometry
    localparam int BOARD_N = 15;
    localparam int CELLS   = BOARD_N * BOARD_N;

    // candidate buffer between scanner and kill node
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // five in a row, so at most four more stones each way
    localparam int WIN_LEN = 5;
    localparam int RUN_MAX = WIN_LEN - 1;

    // row and column steps for horizontal, vertical, diagonal, anti-diagonal
    localparam int DIR_DR [4] = '{0, 1, 1, 1};
    localparam int DIR_DC [4] = '{1, 0, 1, -1};

    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_BLACK = 2'd1,
        CELL_WHITE = 2'd2
    } cell_t;

    // cell at row r, column c lives at r * BOARD_N + c
    typedef cell_t [CELLS-1:0] board_t;

    // index carried next to row/col so nothing has to divide
    typedef struct packed {
        logic [7:0] idx;
        logic [3:0] row;
        logic [3:0] col;
    } move_t;

    typedef enum logic [1:0] {
        KILL_NONE   = 2'd0,
        KILL_WIN1   = 2'd1,
        KILL_DOUBLE = 2'd2
    } kill_kind_t;

    typedef struct packed {
        kill_kind_t kind;
        move_t      move;
    } kill_result_t;

    // step to the next cell in raster order, row wraps at the board edge
    function automatic move_t next_cell(move_t m);
        move_t n;
        n.idx = m.idx + 8'd1;
        if (m.col == 4'(BOARD_N - 1)) begin
            n.row = m.row + 4'd1;
            n.col = 4'd0;
        end else begin
            n.row = m.row;
            n.col = m.col + 4'd1;
        end
        return n;
    endfunction

endpackage
